// File: core_bus_pkg.sv
package core_bus_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  // entries held by each register slice
  localparam int SLICE_DEPTH = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // request channel payload, 69 bits
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // response channel payload
  // read data only, writes return a don't-care word
  typedef struct packed {
    data_t rdata;
  } bus_rsp_t;

endpackage

// File: mem_port_if.sv
interface mem_port_if;

  // handshake
  logic req;
  logic gnt;
  logic rvalid;

  // request fields, held by the core until granted
  core_bus_pkg::addr_t addr;
  logic                we;
  core_bus_pkg::be_t   be;
  core_bus_pkg::data_t wdata;

  // response data, valid together with rvalid
  core_bus_pkg::data_t rdata;

  modport core (
    output req,
    output addr,
    output we,
    output be,
    output wdata,
    input  gnt,
    input  rvalid,
    input  rdata
  );

  modport bridge (
    input  req,
    input  addr,
    input  we,
    input  be,
    input  wdata,
    output gnt,
    output rvalid,
    output rdata
  );

endinterface

// File: core_bus_bridge.sv
module core_bus_bridge #(
  parameter bit READ_ONLY = 1'b0
) (
  input  logic                   clk,
  input  logic                   rst_i,

  // core side
  mem_port_if.bridge             port,

  // request channel
  output logic                   req_valid_o,
  input  logic                   req_ready_i,
  output core_bus_pkg::bus_req_t req_o,

  // response channel
  input  logic                   rsp_valid_i,
  output logic                   rsp_ready_o,
  input  core_bus_pkg::bus_rsp_t rsp_i
);

  // set on grant, cleared when the response comes back
  logic outstanding_q;

  // a new request may only go out when nothing is in flight
  assign req_valid_o = port.req & ~outstanding_q;

  // grant follows the slice ready, gated off while a response is pending
  // this also covers the rvalid cycle itself
  assign port.gnt = req_valid_o & req_ready_i;

  // accept the response only for the transaction we issued
  assign rsp_ready_o = outstanding_q;

  assign port.rvalid = rsp_valid_i & outstanding_q;
  assign port.rdata  = rsp_i.rdata;

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      outstanding_q <= 1'b0;
    end
    else if (port.gnt)
    begin
      outstanding_q <= 1'b1;
    end
    else if (port.rvalid)
    begin
      outstanding_q <= 1'b0;
    end
  end

  assign req_o.addr = port.addr;

  if (READ_ONLY)
  begin : g_read_only
    // fetch port: always a full-word read
    assign req_o.we    = 1'b0;
    assign req_o.be    = '1;
    assign req_o.wdata = '0;
  end
  else
  begin : g_read_write
    assign req_o.we    = port.we;
    assign req_o.be    = port.be;
    assign req_o.wdata = port.wdata;
  end

  // the core holds its request and address until it is granted
  a_req_held : assert property (
    @(posedge clk) disable iff (rst_i)
    (port.req && !port.gnt) |=> (port.req && $stable(port.addr))
  ) else $error("core request dropped or changed before its grant");

  // a response only comes back for a request that is in flight
  a_rsp_needs_req : assert property (
    @(posedge clk) disable iff (rst_i)
    rsp_valid_i |-> outstanding_q
  ) else $error("response without an outstanding transaction");

endmodule

// File: bus_slice.sv
module bus_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_i,

  // upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,

  // downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  typedef logic [$clog2(core_bus_pkg::SLICE_DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(core_bus_pkg::SLICE_DEPTH+1)-1:0] cnt_t;

  payload_t mem_q [core_bus_pkg::SLICE_DEPTH];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  cnt_t     cnt_q;
  cnt_t     cnt_d;
  logic     in_ready_q;
  logic     push;
  logic     pop;

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_comb
  begin
    cnt_d = cnt_q;
    if (push && !pop)
      cnt_d = cnt_q + cnt_t'(1);
    else if (pop && !push)
      cnt_d = cnt_q - cnt_t'(1);
  end

  // ready is registered, so it stays low through reset
  assign in_ready_o  = in_ready_q;
  assign out_valid_o = (cnt_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      cnt_q      <= '0;
      in_ready_q <= 1'b0;
    end
    else
    begin
      cnt_q      <= cnt_d;
      in_ready_q <= (cnt_d < cnt_t'(core_bus_pkg::SLICE_DEPTH));
      if (push)
        wr_ptr_q <= (wr_ptr_q == ptr_t'(core_bus_pkg::SLICE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= (rd_ptr_q == ptr_t'(core_bus_pkg::SLICE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (push)
      mem_q[wr_ptr_q] <= in_data_i;
  end

  // held item must not change under back-pressure
  a_out_stable : assert property (
    @(posedge clk) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> $stable(out_data_o)
  ) else $error("slice output changed while stalled");

  // an item pushed into an empty slice is at the output next cycle
  a_push_visible : assert property (
    @(posedge clk) disable iff (rst_i)
    (push && cnt_q == '0) |=> (out_valid_o && out_data_o == $past(in_data_i))
  ) else $error("pushed item missing from the slice output");

endmodule

// File: core_bus_region.sv
module core_bus_region (
  input  logic                   clk,
  input  logic                   rst_i,

  // instruction fetch port
  input  logic                   fetch_req_i,
  input  core_bus_pkg::addr_t    fetch_addr_i,
  output logic                   fetch_gnt_o,
  output logic                   fetch_rvalid_o,
  output core_bus_pkg::data_t    fetch_rdata_o,

  // load/store port
  input  logic                   data_req_i,
  input  core_bus_pkg::addr_t    data_addr_i,
  input  logic                   data_we_i,
  input  core_bus_pkg::be_t      data_be_i,
  input  core_bus_pkg::data_t    data_wdata_i,
  output logic                   data_gnt_o,
  output logic                   data_rvalid_o,
  output core_bus_pkg::data_t    data_rdata_o,

  // instruction bus master
  output logic                   ibus_req_valid_o,
  input  logic                   ibus_req_ready_i,
  output core_bus_pkg::bus_req_t ibus_req_o,
  input  logic                   ibus_rsp_valid_i,
  output logic                   ibus_rsp_ready_o,
  input  core_bus_pkg::bus_rsp_t ibus_rsp_i,

  // data bus master
  output logic                   dbus_req_valid_o,
  input  logic                   dbus_req_ready_i,
  output core_bus_pkg::bus_req_t dbus_req_o,
  input  logic                   dbus_rsp_valid_i,
  output logic                   dbus_rsp_ready_o,
  input  core_bus_pkg::bus_rsp_t dbus_rsp_i
);

  // bridge to slice channels
  logic                   fetch_req_valid;
  logic                   fetch_req_ready;
  core_bus_pkg::bus_req_t fetch_req;
  logic                   fetch_rsp_valid;
  logic                   fetch_rsp_ready;
  core_bus_pkg::bus_rsp_t fetch_rsp;

  logic                   data_req_valid;
  logic                   data_req_ready;
  core_bus_pkg::bus_req_t data_req;
  logic                   data_rsp_valid;
  logic                   data_rsp_ready;
  core_bus_pkg::bus_rsp_t data_rsp;

  mem_port_if fetch_port ();
  mem_port_if data_port ();

  // fetch port carries no write fields
  assign fetch_port.req = fetch_req_i;
  assign fetch_port.addr = fetch_addr_i;
  assign fetch_gnt_o = fetch_port.gnt;
  assign fetch_rvalid_o = fetch_port.rvalid;
  assign fetch_rdata_o = fetch_port.rdata;

  assign data_port.req = data_req_i;
  assign data_port.addr = data_addr_i;
  assign data_port.we = data_we_i;
  assign data_port.be = data_be_i;
  assign data_port.wdata = data_wdata_i;
  assign data_gnt_o = data_port.gnt;
  assign data_rvalid_o = data_port.rvalid;
  assign data_rdata_o = data_port.rdata;

  core_bus_bridge #(
    .READ_ONLY ( 1'b1 )
  ) fetch_bridge (
    .clk         ( clk             ),
    .rst_i       ( rst_i           ),
    .port        ( fetch_port      ),
    .req_valid_o ( fetch_req_valid ),
    .req_ready_i ( fetch_req_ready ),
    .req_o       ( fetch_req       ),
    .rsp_valid_i ( fetch_rsp_valid ),
    .rsp_ready_o ( fetch_rsp_ready ),
    .rsp_i       ( fetch_rsp       )
  );

  core_bus_bridge #(
    .READ_ONLY ( 1'b0 )
  ) data_bridge (
    .clk         ( clk            ),
    .rst_i       ( rst_i          ),
    .port        ( data_port      ),
    .req_valid_o ( data_req_valid ),
    .req_ready_i ( data_req_ready ),
    .req_o       ( data_req       ),
    .rsp_valid_i ( data_rsp_valid ),
    .rsp_ready_o ( data_rsp_ready ),
    .rsp_i       ( data_rsp       )
  );

  // request slices, bridge towards the outside bus
  bus_slice #(
    .payload_t ( core_bus_pkg::bus_req_t )
  ) fetch_req_slice (
    .clk         ( clk              ),
    .rst_i       ( rst_i            ),
    .in_valid_i  ( fetch_req_valid  ),
    .in_ready_o  ( fetch_req_ready  ),
    .in_data_i   ( fetch_req        ),
    .out_valid_o ( ibus_req_valid_o ),
    .out_ready_i ( ibus_req_ready_i ),
    .out_data_o  ( ibus_req_o       )
  );

  bus_slice #(
    .payload_t ( core_bus_pkg::bus_req_t )
  ) data_req_slice (
    .clk         ( clk              ),
    .rst_i       ( rst_i            ),
    .in_valid_i  ( data_req_valid   ),
    .in_ready_o  ( data_req_ready   ),
    .in_data_i   ( data_req         ),
    .out_valid_o ( dbus_req_valid_o ),
    .out_ready_i ( dbus_req_ready_i ),
    .out_data_o  ( dbus_req_o       )
  );

  // response slices, outside bus back to the bridges
  bus_slice #(
    .payload_t ( core_bus_pkg::bus_rsp_t )
  ) fetch_rsp_slice (
    .clk         ( clk              ),
    .rst_i       ( rst_i            ),
    .in_valid_i  ( ibus_rsp_valid_i ),
    .in_ready_o  ( ibus_rsp_ready_o ),
    .in_data_i   ( ibus_rsp_i       ),
    .out_valid_o ( fetch_rsp_valid  ),
    .out_ready_i ( fetch_rsp_ready  ),
    .out_data_o  ( fetch_rsp        )
  );

  bus_slice #(
    .payload_t ( core_bus_pkg::bus_rsp_t )
  ) data_rsp_slice (
    .clk         ( clk              ),
    .rst_i       ( rst_i            ),
    .in_valid_i  ( dbus_rsp_valid_i ),
    .in_ready_o  ( dbus_rsp_ready_o ),
    .in_data_i   ( dbus_rsp_i       ),
    .out_valid_o ( data_rsp_valid   ),
    .out_ready_i ( data_rsp_ready   ),
    .out_data_o  ( data_rsp         )
  );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst_i
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    rst_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
  end

endmodule

// File: tb_core_bus_region.sv
module tb_core_bus_region;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 3000;

  logic clk;
  logic rst_i;

  // core side stimulus
  logic                   fetch_req_i;
  core_bus_pkg::addr_t    fetch_addr_i;
  logic                   fetch_gnt_o;
  logic                   fetch_rvalid_o;
  core_bus_pkg::data_t    fetch_rdata_o;
  logic                   data_req_i;
  core_bus_pkg::addr_t    data_addr_i;
  logic                   data_we_i;
  core_bus_pkg::be_t      data_be_i;
  core_bus_pkg::data_t    data_wdata_i;
  logic                   data_gnt_o;
  logic                   data_rvalid_o;
  core_bus_pkg::data_t    data_rdata_o;

  // outside buses, index 0 is the instruction bus, 1 the data bus
  logic                   bus_req_valid [2];
  logic                   bus_req_ready [2];
  core_bus_pkg::bus_req_t bus_req       [2];
  logic                   bus_rsp_valid [2];
  logic                   bus_rsp_ready [2];
  core_bus_pkg::bus_rsp_t bus_rsp       [2];
  logic                   port_gnt      [2];

  // responder state
  logic [31:0]            mem [2][256];
  logic [31:0]            lfsr_q;
  logic                   stall_mode;
  int                     delay_q [2];
  logic                   busy_q  [2];
  int                     occ_q   [2];
  core_bus_pkg::bus_req_t seen_q  [2][$];

  int errors;
  int tests_passed;
  int tests_failed;
  int cycles;

  tb_clock_gen clock_gen (
    .clk   ( clk   ),
    .rst_i ( rst_i )
  );

  core_bus_region dut (
    .clk              ( clk              ),
    .rst_i            ( rst_i            ),
    .fetch_req_i      ( fetch_req_i      ),
    .fetch_addr_i     ( fetch_addr_i     ),
    .fetch_gnt_o      ( fetch_gnt_o      ),
    .fetch_rvalid_o   ( fetch_rvalid_o   ),
    .fetch_rdata_o    ( fetch_rdata_o    ),
    .data_req_i       ( data_req_i       ),
    .data_addr_i      ( data_addr_i      ),
    .data_we_i        ( data_we_i        ),
    .data_be_i        ( data_be_i        ),
    .data_wdata_i     ( data_wdata_i     ),
    .data_gnt_o       ( data_gnt_o       ),
    .data_rvalid_o    ( data_rvalid_o    ),
    .data_rdata_o     ( data_rdata_o     ),
    .ibus_req_valid_o ( bus_req_valid[0] ),
    .ibus_req_ready_i ( bus_req_ready[0] ),
    .ibus_req_o       ( bus_req[0]       ),
    .ibus_rsp_valid_i ( bus_rsp_valid[0] ),
    .ibus_rsp_ready_o ( bus_rsp_ready[0] ),
    .ibus_rsp_i       ( bus_rsp[0]       ),
    .dbus_req_valid_o ( bus_req_valid[1] ),
    .dbus_req_ready_i ( bus_req_ready[1] ),
    .dbus_req_o       ( bus_req[1]       ),
    .dbus_rsp_valid_i ( bus_rsp_valid[1] ),
    .dbus_rsp_ready_o ( bus_rsp_ready[1] ),
    .dbus_rsp_i       ( bus_rsp[1]       )
  );

  assign port_gnt[0] = fetch_gnt_o;
  assign port_gnt[1] = data_gnt_o;

  // initial memory contents, distinct per bus and per word address
  function automatic logic [31:0] fill_word(input int b, input core_bus_pkg::addr_t a);
    logic [31:0] base;
    base = (b == 0) ? 32'h1ce00000 : 32'hd00d0000;
    return (a * 32'h9e3779b1) ^ base;
  endfunction

  // byte lane merge of a write into an old word
  function automatic core_bus_pkg::data_t merge_bytes(input core_bus_pkg::data_t old_w,
                                                      input core_bus_pkg::data_t new_w,
                                                      input core_bus_pkg::be_t be);
    core_bus_pkg::data_t res;
    res = old_w;
    for (int i = 0; i < core_bus_pkg::BE_W; i++)
      if (be[i])
        res[i*8 +: 8] = new_w[i*8 +: 8];
    return res;
  endfunction

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int unsigned v);
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      v = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_word(input core_bus_pkg::data_t got, input core_bus_pkg::data_t exp,
                            input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t: %s data %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_req(input core_bus_pkg::bus_req_t got,
                           input core_bus_pkg::bus_req_t exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t: %s request %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_low(input logic got, input string what);
    if (got !== 1'b0)
    begin
      $display("[FAIL] %0t: %s is %b, expected 0", $time, what, got);
      errors++;
    end
  endtask

  // behavioral responder for both outside buses
  initial
  begin
    lfsr_q = 32'h1397aacc;
    stall_mode = 1'b0;
    for (int b = 0; b < 2; b++)
    begin
      bus_req_ready[b] = 1'b0;
      bus_rsp_valid[b] = 1'b0;
      bus_rsp[b] = '0;
      busy_q[b] = 1'b0;
      delay_q[b] = 0;
      occ_q[b] = 0;
      for (int w = 0; w < 256; w++)
        mem[b][w] = fill_word(b, core_bus_pkg::addr_t'(w * 4));
    end
  end

  always @(posedge clk)
  begin
    int unsigned r;
    core_bus_pkg::bus_req_t q;
    int idx;
    if (rst_i)
    begin
      for (int b = 0; b < 2; b++)
      begin
        bus_req_ready[b] <= 1'b0;
        bus_rsp_valid[b] <= 1'b0;
        busy_q[b] = 1'b0;
        occ_q[b] = 0;
      end
    end
    else
    begin
      for (int b = 0; b < 2; b++)
      begin
        // slice occupancy as seen from both of its sides
        if (port_gnt[b] && occ_q[b] == core_bus_pkg::SLICE_DEPTH)
        begin
          $display("[FAIL] %0t: gnt on bus %0d with a full request slice", $time, b);
          errors++;
        end
        occ_q[b] = occ_q[b] + int'(port_gnt[b]) - int'(bus_req_valid[b] && bus_req_ready[b]);
        if (bus_rsp_valid[b] && bus_rsp_ready[b])
        begin
          bus_rsp_valid[b] <= 1'b0;
          busy_q[b] = 1'b0;
        end
        else if (busy_q[b] && !bus_rsp_valid[b])
        begin
          if (delay_q[b] == 0)
            bus_rsp_valid[b] <= 1'b1;
          else
            delay_q[b]--;
        end
        if (bus_req_valid[b] && bus_req_ready[b])
        begin
          q = bus_req[b];
          idx = int'(q.addr[9:2]);
          if (busy_q[b])
          begin
            $display("second request on bus %0d before the first was answered", b);
            errors++;
          end
          seen_q[b].push_back(q);
          if (q.we)
            mem[b][idx] = merge_bytes(mem[b][idx], q.wdata, q.be);
          bus_rsp[b] <= '{rdata: mem[b][idx]};
          busy_q[b] = 1'b1;
          r = 0;
          if (stall_mode)
            take_bits(2, r);
          delay_q[b] = int'(r);
        end
        r = 1;
        if (stall_mode)
          take_bits(1, r);
        bus_req_ready[b] <= r[0];
      end
    end
  end

  // n fetches, the next request is driven right after each grant
  task automatic fetch_seq(input int n, input core_bus_pkg::addr_t base);
    int issued;
    int done;
    logic waiting;
    core_bus_pkg::addr_t a;
    core_bus_pkg::addr_t exp_q[$];
    issued = 0;
    done = 0;
    waiting = 1'b0;
    fetch_req_i <= 1'b1;
    fetch_addr_i <= base;
    exp_q.push_back(base);
    while (done < n)
    begin
      @(posedge clk);
      if (fetch_gnt_o)
      begin
        if (waiting)
        begin
          $display("fetch gnt rose before the previous rvalid at %0t", $time);
          errors++;
        end
        waiting = 1'b1;
        issued++;
        if (issued < n)
        begin
          a = base + core_bus_pkg::addr_t'(issued * 4);
          fetch_addr_i <= a;
          exp_q.push_back(a);
        end
        else
          fetch_req_i <= 1'b0;
      end
      else if (fetch_rvalid_o)
      begin
        if (!waiting || exp_q.size() == 0 || seen_q[0].size() == 0)
        begin
          $display("fetch rvalid without a matching request at %0t", $time);
          errors++;
        end
        else
        begin
          a = exp_q.pop_front();
          check_req(seen_q[0].pop_front(), '{addr: a, we: 1'b0, be: '1, wdata: '0}, "fetch");
          check_word(fetch_rdata_o, fill_word(0, a), "fetch");
        end
        waiting = 1'b0;
        done++;
      end
    end
  endtask

  // one load or store on the data port
  task automatic data_access(input logic we, input core_bus_pkg::addr_t a,
                             input core_bus_pkg::be_t be, input core_bus_pkg::data_t wd,
                             output core_bus_pkg::data_t rd);
    logic granted;
    granted = 1'b0;
    data_req_i <= 1'b1;
    data_addr_i <= a;
    data_we_i <= we;
    data_be_i <= be;
    data_wdata_i <= wd;
    forever
    begin
      @(posedge clk);
      if (data_gnt_o)
      begin
        if (granted)
        begin
          $display("data gnt rose twice for one access at %0t", $time);
          errors++;
        end
        granted = 1'b1;
        data_req_i <= 1'b0;
      end
      else if (data_rvalid_o)
        break;
    end
    rd = data_rdata_o;
    if (!granted || seen_q[1].size() == 0)
    begin
      $display("data rvalid without a matching request at %0t", $time);
      errors++;
    end
    else
      check_req(seen_q[1].pop_front(), '{addr: a, we: we, be: be, wdata: wd}, "data");
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    // registers take their reset values at the first edge
    @(posedge clk);
    while (rst_i)
    begin
      @(posedge clk);
      check_low(fetch_gnt_o, "fetch_gnt_o");
      check_low(data_gnt_o, "data_gnt_o");
      check_low(fetch_rvalid_o, "fetch_rvalid_o");
      check_low(data_rvalid_o, "data_rvalid_o");
      check_low(bus_req_valid[0], "ibus_req_valid_o");
      check_low(bus_req_valid[1], "dbus_req_valid_o");
      check_low(bus_rsp_ready[0], "ibus_rsp_ready_o");
      check_low(bus_rsp_ready[1], "dbus_rsp_ready_o");
    end
    @(posedge clk);
    check_low(fetch_gnt_o, "fetch_gnt_o");
    check_low(data_rvalid_o, "data_rvalid_o");
    check_low(bus_req_valid[0], "ibus_req_valid_o");
    finish_test("reset", e0);
  endtask

  // data port traffic, shadow holds the expected memory image
  task automatic data_traffic(input int n, input core_bus_pkg::addr_t base);
    core_bus_pkg::data_t shadow [256];
    core_bus_pkg::data_t rd;
    core_bus_pkg::data_t wd;
    core_bus_pkg::addr_t a;
    core_bus_pkg::be_t be;
    for (int w = 0; w < 256; w++)
      shadow[w] = core_bus_pkg::data_t'(mem[1][w]);
    for (int k = 0; k < n; k++)
    begin
      a = base + core_bus_pkg::addr_t'(k * 4);
      be = core_bus_pkg::be_t'(k % 15 + 1);
      wd = 32'hc0de0000 + core_bus_pkg::data_t'(k * 32'h01010101);
      data_access(1'b1, a, be, wd, rd);
      shadow[a[9:2]] = merge_bytes(shadow[a[9:2]], wd, be);
    end
    for (int k = 0; k < n; k++)
    begin
      a = base + core_bus_pkg::addr_t'(k * 4);
      data_access(1'b0, a, 4'hf, '0, rd);
      check_word(rd, shadow[a[9:2]], "data read");
    end
  endtask

  initial
  begin
    int e0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    data_req_i = 1'b0;
    data_addr_i = '0;
    data_we_i = 1'b0;
    data_be_i = '0;
    data_wdata_i = '0;

    test_reset();

    e0 = errors;
    fetch_seq(1, 32'h40);
    fetch_seq(1, 32'h1c4);
    finish_test("fetch reads", e0);

    e0 = errors;
    data_traffic(6, 32'h80);
    finish_test("data writes then reads", e0);

    e0 = errors;
    fetch_seq(8, 32'h300);
    finish_test("one outstanding", e0);

    e0 = errors;
    stall_mode <= 1'b1;
    fork
      fetch_seq(12, 32'h100);
      data_traffic(8, 32'h200);
    join
    finish_test("back-pressure", e0);

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog
  initial
    cycles = 0;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("run stopped after %0d cycles, a transaction never completed", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

endmodule

// File: core_bus_region.f
core_bus_pkg.sv
mem_port_if.sv
core_bus_bridge.sv
bus_slice.sv
core_bus_region.sv
tb_clock_gen.sv
tb_core_bus_region.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f core_bus_region.f \
  --top-module tb_core_bus_region \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
fi
exit 1
